/* saturn_bus_pkg.sv */
/*
 * shared definitions for the nibble bus controller
 *   list depth and pointer width, register addresses
 *   program entry, bus output, register write and phase structs
 */

package saturn_bus_pkg;

    // ========================================================================
    // sizes and addresses
    // ========================================================================

    localparam int PROG_DEPTH = 32;        // queued nibbles held by the list
    localparam int PROG_AW    = 5;         // list pointer width

    localparam logic [1:0] REG_NO_READ = 2'd0;   // read-inhibit register
    localparam logic [1:0] REG_CLR_ERR = 2'd1;   // write strobe clears error

    // ========================================================================
    // structs
    // ========================================================================

    // one entry of the program list
    typedef struct packed {
        logic       cmd;                   // 1 = command nibble, 0 = data
        logic [3:0] nibble;
    } prog_entry_t;

    // what the controller drives onto the nibble bus
    typedef struct packed {
        logic       strobe;                // bus strobe enable, one step wide
        logic       is_data;               // high for data and read cycles
        logic [3:0] nibble;
    } bus_out_t;

    // register write port from the core side
    typedef struct packed {
        logic       wr;                    // write strobe
        logic [1:0] addr;
        logic       data;
    } reg_wr_t;

    // bus phase state, broadcast from the phase generator
    typedef struct packed {
        logic [3:0]  phases;               // one-hot, 0001 -> 1000
        logic [1:0]  idx;                  // phase index 0..3
        logic [31:0] cycle_ctr;            // full bus cycles done
        logic        step;                 // phase advances on this clock
    } phase_t;

endpackage

/* saturn_phase_gen.sv */
/*
 * four-phase bus clock generator
 * rotates the one-hot phases on each step and counts bus cycles
 */

`timescale 1ns/1ps

module saturn_phase_gen import saturn_bus_pkg::*; (
    input  logic   i_clk,
    input  logic   i_reset,
    input  logic   i_clk_en,
    input  logic   i_hold,                 // debug hold or halt
    output phase_t o_phase
);

    logic [3:0]  phases;
    logic [1:0]  idx;
    logic [31:0] cycle_ctr;
    logic        step;

    assign step = i_clk_en && !i_hold;     // frozen while held

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phases    <= 4'b0001;
            idx       <= 2'd0;
            cycle_ctr <= 32'd0;
        end else if (step) begin
            phases <= {phases[2:0], phases[3]};  // rotate left
            idx    <= idx + 2'd1;                // wraps with the phases
            if (phases[3])
                cycle_ctr <= cycle_ctr + 32'd1;  // one full cycle done
        end
    end

    assign o_phase = '{phases: phases, idx: idx, cycle_ctr: cycle_ctr, step: step};

    // one-hot and in step with the index at all times
    a_phase_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot(phases) && (phases == (4'b0001 << idx)));

endmodule

/* saturn_prog_list.sv */
/*
 * program list: ring of queued command/data nibbles
 * write and read pointers with an occupancy count, overflow pulse
 */

`timescale 1ns/1ps

module saturn_prog_list import saturn_bus_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_wr,
    input  prog_entry_t i_wr_entry,
    input  logic        i_pop,
    output prog_entry_t o_head,
    output logic        o_pending,
    output logic        o_overflow
);

    prog_entry_t        mem [PROG_DEPTH];
    logic [PROG_AW-1:0] wr_ptr;
    logic [PROG_AW-1:0] rd_ptr;
    logic [PROG_AW:0]   count;             // one bit wider, tells full from empty
    logic               full;
    logic               wr_ok;

    assign full       = (count == (PROG_AW+1)'(PROG_DEPTH));
    assign wr_ok      = i_wr && !full;
    assign o_overflow = i_wr && full;      // write dropped this clock

    // entry storage
    always_ff @(posedge i_clk) begin
        if (wr_ok)
            mem[wr_ptr] <= i_wr_entry;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (i_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // pointers are equal when full too, so look at the count
    assign o_pending = (count != '0);
    assign o_head    = mem[rd_ptr];

    // the sequencer only pops what is there
    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pop |-> o_pending);

endmodule

/* saturn_bus_regs.sv */
/*
 * bus control registers
 * read-inhibit level and sticky overflow error driving halt
 */

`timescale 1ns/1ps

module saturn_bus_regs import saturn_bus_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,
    input  reg_wr_t i_reg_wr,
    input  logic    i_overflow,            // from the program list
    output logic    o_no_read,
    output logic    o_halt
);

    logic no_read;
    logic error;
    logic clr_err;

    // error clear is a strobe, data bit ignored
    assign clr_err = i_reg_wr.wr && (i_reg_wr.addr == REG_CLR_ERR);

    // ========================================================================
    // no-read register
    // ========================================================================

    always_ff @(posedge i_clk) begin
        if (i_reset)
            no_read <= 1'b0;
        else if (i_reg_wr.wr && (i_reg_wr.addr == REG_NO_READ))
            no_read <= i_reg_wr.data;
    end

    // ========================================================================
    // sticky error
    // ========================================================================

    always_ff @(posedge i_clk) begin
        if (i_reset)
            error <= 1'b0;
        else if (i_overflow)
            error <= 1'b1;                 // set beats clear
        else if (clr_err)
            error <= 1'b0;
    end

    assign o_no_read = no_read;
    assign o_halt    = error;              // bus stops while in error

endmodule

/* saturn_bus_sequencer.sv */
/*
 * bus cycle engine
 * sends queued nibbles or runs a read in phase 0001, ends the strobe and
 * captures read data in phase 0010, drops busy in phase 0100
 */

`timescale 1ns/1ps

module saturn_bus_sequencer import saturn_bus_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  phase_t      i_phase,
    input  prog_entry_t i_head,
    input  logic        i_pending,
    input  logic        i_no_read,
    input  logic [3:0]  i_bus_nibble,
    output logic        o_pop,
    output bus_out_t    o_bus,
    output logic        o_rd_valid,
    output logic [3:0]  o_rd_nibble
    ,
    output logic        o_busy
);

    bus_out_t   bus;
    logic       rd_cycle;                  // current bus cycle is a read
    logic       rd_valid;
    logic [3:0] rd_nibble;
    logic       busy;

    // pop the head on the first phase of a cycle
    assign o_pop = i_phase.step && i_phase.phases[0] && i_pending;

    // ========================================================================
    // per-phase cycle engine
    // ========================================================================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            bus      <= '0;
            rd_cycle <= 1'b0;
            rd_valid <= 1'b0;
            busy     <= 1'b1;              // busy until list seen empty
        end else begin
            rd_valid <= 1'b0;              // single clock pulse
            if (i_phase.step) begin
                case (i_phase.phases)
                    4'b0001: begin
                        if (i_pending) begin
                            bus.strobe  <= 1'b1;
                            bus.is_data <= !i_head.cmd;
                            bus.nibble  <= i_head.nibble;
                            busy        <= 1'b1;
                            rd_cycle    <= 1'b0;
                        end else if (!i_no_read) begin
                            // read cycle, nibble left as it was
                            bus.strobe  <= 1'b1;
                            bus.is_data <= 1'b1;
                            rd_cycle    <= 1'b1;
                        end else begin
                            rd_cycle    <= 1'b0;   // idle cycle
                        end
                    end
                    4'b0010: begin
                        bus.strobe <= 1'b0;
                        if (rd_cycle) begin
                            rd_valid <= 1'b1;      // data sampled below
                            rd_cycle <= 1'b0;
                        end
                    end
                    4'b0100: begin
                        if (!i_pending)
                            busy <= 1'b0;          // everything sent
                    end
                    4'b1000: ;                     // nothing on the bus
                    default: ;
                endcase
            end
        end
    end

    // read data register
    always_ff @(posedge i_clk) begin
        if (i_phase.step && i_phase.phases[1] && rd_cycle)
            rd_nibble <= i_bus_nibble;
    end

    assign o_bus       = bus;
    assign o_rd_valid  = rd_valid;
    assign o_rd_nibble = rd_nibble;
    assign o_busy      = busy;

    // strobe is dropped by the step after the one that raised it
    a_strobe_one_step: assert property (@(posedge i_clk) disable iff (i_reset)
        (bus.strobe && i_phase.step) |=> !bus.strobe);

endmodule

/* saturn_bus_top.sv */
/*
 * nibble bus controller subsystem
 * phase generator, program list, control registers and bus sequencer
 */

`timescale 1ns/1ps

module saturn_bus_top import saturn_bus_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_clk_en,
    input  logic        i_debug_hold,      // debugger freezes the bus
    input  logic        i_prog_wr,         // queue one entry
    input  prog_entry_t i_prog_entry,
    input  reg_wr_t     i_reg_wr,
    input  logic [3:0]  i_bus_nibble,
    output bus_out_t    o_bus,
    output logic        o_rd_valid,
    output logic [3:0]  o_rd_nibble,
    output logic        o_busy,
    output logic        o_halt,
    output logic [31:0] o_cycle_ctr
);

    phase_t      phase;
    prog_entry_t head;
    logic        pending;
    logic        overflow;
    logic        pop;
    logic        no_read;
    logic        halt;
    wire         phase_hold = i_debug_hold || halt;   // either one stops the phases

    // ========================================================================
    // instances
    // ========================================================================

    saturn_phase_gen u_phase_gen (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_clk_en (i_clk_en),
        .i_hold   (phase_hold),
        .o_phase  (phase)
    );

    saturn_prog_list u_prog_list (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wr       (i_prog_wr),
        .i_wr_entry (i_prog_entry),
        .i_pop      (pop),
        .o_head     (head),
        .o_pending  (pending),
        .o_overflow (overflow)
    );

    saturn_bus_regs u_bus_regs (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_reg_wr   (i_reg_wr),
        .i_overflow (overflow),
        .o_no_read  (no_read),
        .o_halt     (halt)
    );

    saturn_bus_sequencer u_sequencer (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_phase      (phase),
        .i_head       (head),
        .i_pending    (pending),
        .i_no_read    (no_read),
        .i_bus_nibble (i_bus_nibble),
        .o_pop        (pop),
        .o_bus        (o_bus),
        .o_rd_valid   (o_rd_valid),
        .o_rd_nibble  (o_rd_nibble),
        .o_busy       (o_busy)
    );

    assign o_halt      = halt;
    assign o_cycle_ctr = phase.cycle_ctr;

endmodule

/* tb_saturn_bus.sv */
/*
 * testbench for the nibble bus controller
 * clock and reset, LFSR stimulus, reference queue model of the list,
 * concurrent checks on the bus outputs and a watchdog
 */

`timescale 1ns/1ps

module tb_saturn_bus import saturn_bus_pkg::*; ();

    // ========================================================================
    // run length and the watchdog sized from it
    // ========================================================================

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CLOCKS = 4;
    localparam int RUN_CLOCKS   = 1000;            // random + drain + no-read + overflow
    localparam int WDOG_CLOCKS  = 4 * RUN_CLOCKS;  // wide margin for the final drain

    logic        i_clk, i_reset, i_clk_en, i_debug_hold, i_prog_wr;
    prog_entry_t i_prog_entry;
    reg_wr_t     i_reg_wr;
    logic [3:0]  i_bus_nibble;
    bus_out_t    o_bus, prev_bus;
    logic        o_rd_valid, o_busy, o_halt;
    logic [3:0]  o_rd_nibble;
    logic [31:0] o_cycle_ctr;
    logic [31:0] lfsr = 32'h7cf5_628a;

    // reference model state of the list, the bus and the registers
    prog_entry_t exp_q[$];
    logic        m_strobe, m_isdata, m_rd, m_rd_due, m_busy, m_err, m_no_read, m_frozen;
    logic [3:0]  m_nib, m_rd_exp;
    logic [1:0]  m_phase;                          // index of the current phase
    logic [31:0] m_cycles;
    int          n_sent, n_reads, n_halted;

    saturn_bus_top i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %0t: %s is %0h, expected %0h", $time, sig, got, exp);
        abort_run();
    endtask

    // ========================================================================
    // reference model, follows the phase rules of the bus
    // ========================================================================

    always @(posedge i_clk) begin : model
        prog_entry_t ent;
        logic        step, pend, full;
        step = i_clk_en && !i_debug_hold && !m_err;
        pend = (exp_q.size() != 0);
        full = (exp_q.size() == PROG_DEPTH);       // size before this clock's pop
        if (i_reset) begin
            exp_q.delete();
            {m_strobe, m_isdata, m_rd, m_rd_due, m_err, m_no_read, m_frozen} <= '0;
            m_busy <= 1'b1;
            {m_nib, m_phase, m_cycles} <= '0;
        end else begin
            m_rd_due <= 1'b0;
            m_frozen <= !step;
            prev_bus <= o_bus;
            if (step) begin
                if (m_phase == 2'd0 && pend) begin  // send oldest entry
                    ent = exp_q.pop_front();
                    {m_strobe, m_rd, m_busy} <= 3'b101;
                    m_isdata <= !ent.cmd;
                    m_nib    <= ent.nibble;
                    n_sent++;
                end else if (m_phase == 2'd0 && !m_no_read) begin
                    {m_strobe, m_isdata, m_rd} <= 3'b111;   // read cycle
                    n_reads++;
                end else if (m_phase == 2'd0) begin
                    m_rd <= 1'b0;
                end else if (m_phase == 2'd1) begin
                    m_strobe <= 1'b0;
                    m_rd_due <= m_rd;
                    m_rd_exp <= i_bus_nibble;      // value on the bus during 0010
                    m_rd     <= 1'b0;
                end else if (m_phase == 2'd2 && !pend) begin
                    m_busy <= 1'b0;
                end
                m_phase <= m_phase + 2'd1;
                if (m_phase == 2'd3)
                    m_cycles <= m_cycles + 32'd1;
            end
            if (i_prog_wr && !full)
                exp_q.push_back(i_prog_entry);
            if (i_reg_wr.wr && i_reg_wr.addr == REG_NO_READ)
                m_no_read <= i_reg_wr.data;
            if (i_reg_wr.wr && i_reg_wr.addr == REG_CLR_ERR)
                m_err <= 1'b0;
            if (i_prog_wr && full)
                m_err <= 1'b1;                     // overflow wins over clear
            if (m_err)
                n_halted++;
        end
    end

    // ========================================================================
    // checks
    // ========================================================================

    a_bus: assert property (@(posedge i_clk) disable iff (i_reset)
        o_bus == {m_strobe, m_isdata, m_nib})
        else report_mismatch("o_bus", 32'($sampled(o_bus)),
                             32'($sampled({m_strobe, m_isdata, m_nib})));
    a_rd_valid: assert property (@(posedge i_clk) disable iff (i_reset) o_rd_valid == m_rd_due)
        else report_mismatch("o_rd_valid", 32'($sampled(o_rd_valid)), 32'($sampled(m_rd_due)));
    a_rd_nibble: assert property (@(posedge i_clk) disable iff (i_reset)
        o_rd_valid |-> o_rd_nibble == m_rd_exp)
        else report_mismatch("o_rd_nibble", 32'($sampled(o_rd_nibble)), 32'($sampled(m_rd_exp)));
    a_busy: assert property (@(posedge i_clk) disable iff (i_reset) o_busy == m_busy)
        else report_mismatch("o_busy", 32'($sampled(o_busy)), 32'($sampled(m_busy)));
    a_halt: assert property (@(posedge i_clk) disable iff (i_reset) o_halt == m_err)
        else report_mismatch("o_halt", 32'($sampled(o_halt)), 32'($sampled(m_err)));
    a_cycles: assert property (@(posedge i_clk) disable iff (i_reset) o_cycle_ctr == m_cycles)
        else report_mismatch("o_cycle_ctr", $sampled(o_cycle_ctr), $sampled(m_cycles));
    a_phases: assert property (@(posedge i_clk) disable iff (i_reset)
        i_dut.phase.phases == (4'b0001 << m_phase))
        else report_mismatch("phases", 32'($sampled(i_dut.phase.phases)),
                             32'($sampled(4'b0001 << m_phase)));
    a_freeze: assert property (@(posedge i_clk) disable iff (i_reset)
        m_frozen |-> o_bus == prev_bus)            // bus unchanged across a frozen clock
        else report_mismatch("o_bus frozen", 32'($sampled(o_bus)), 32'($sampled(prev_bus)));

    // ========================================================================
    // stimulus
    // ========================================================================

    task automatic run_random(input int clocks, input logic allow_wr);
        logic wr;
        repeat (clocks) begin
            @(posedge i_clk);
            wr = (take_bits(3) == 32'd0);          // one write in eight clocks
            i_clk_en     <= (take_bits(2) != 32'd0);
            i_debug_hold <= (take_bits(3) == 32'd0);
            i_prog_wr    <= allow_wr && wr;
            i_prog_entry <= 5'(take_bits(5));
            i_bus_nibble <= 4'(take_bits(4));
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic data);
        @(posedge i_clk);
        i_reg_wr <= '{wr: 1'b1, addr: addr, data: data};
        @(posedge i_clk);
        i_reg_wr <= '0;
    endtask

    initial begin
        {i_reset, i_clk_en, i_debug_hold, i_prog_wr} = 4'b1000;
        i_prog_entry = '0;
        i_reg_wr     = '0;
        i_bus_nibble = '0;
        repeat (RESET_CLOCKS) @(posedge i_clk);
        i_reset <= 1'b0;
        run_random(400, 1'b1);                     // sends mixed with reads
        run_random(200, 1'b0);                     // list empty, reads only
        write_reg(REG_NO_READ, 1'b1);
        run_random(80, 1'b0);
        @(posedge i_clk);
        {i_clk_en, i_debug_hold, i_prog_wr} <= 3'b111;   // hold the bus, fill the list
        repeat (PROG_DEPTH + 1) begin
            i_prog_entry <= 5'(take_bits(5));
            @(posedge i_clk);
        end
        {i_debug_hold, i_prog_wr} <= 2'b00;
        repeat (20) @(posedge i_clk);              // halted, bus must stay put
        write_reg(REG_CLR_ERR, 1'b0);
        // first pop after the clear raises busy, it drops once all 32 are sent
        while (!o_busy)
            @(negedge i_clk);
        while (o_busy)
            @(negedge i_clk);
        repeat (12) @(posedge i_clk);
        if (n_sent < PROG_DEPTH + 10 || n_reads == 0 || n_halted < 15) begin
            $display("stimulus missed sends, reads or the overflow halt");
            abort_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    initial begin : watchdog
        repeat (WDOG_CLOCKS) @(posedge i_clk);
        $display("timeout: run did not end within %0d clocks", WDOG_CLOCKS);
        abort_run();
    end

endmodule

/* project.f */
saturn_bus_pkg.sv
saturn_phase_gen.sv
saturn_prog_list.sv
saturn_bus_regs.sv
saturn_bus_sequencer.sv
saturn_bus_top.sv
tb_saturn_bus.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_saturn_bus -f project.f

# the simulator status is lost in the pipe, the log decides
./obj_dir/Vtb_saturn_bus | tee sim.log
grep -qx "TEST OK" sim.log
